/* rtl/wrra_consts.svh */
`ifndef WRRA_CONSTS_SVH
`define WRRA_CONSTS_SVH

// switch geometry, port 0 is the local port
`define WRRA_P 5

// flit layout
`define WRRA_FLIT_W 32
`define WRRA_DEST_W 3  // destination port index
`define WRRA_WEIGHT_W 4  // weight and contention value
`define WRRA_PAYLOAD_W 23  // header bits after dest and weight
`define WRRA_DATA_W 30  // body bits after hdr and tail

// contention adder width, holds WRRA_P full-scale weights
`define WRRA_SUM_W 7

`endif

/* rtl/wrra_pkg.sv */
`include "wrra_consts.svh"

package wrra_pkg;

    typedef logic [`WRRA_DEST_W-1:0] port_idx_t;
    typedef logic [`WRRA_WEIGHT_W-1:0] weight_t;
    typedef logic [`WRRA_P-1:0] port_vec_t;  // one bit per port

    typedef struct packed {
        logic hdr;
        logic tail;
        port_idx_t dest;
        weight_t weight;
        logic [`WRRA_PAYLOAD_W-1:0] payload;
    } head_view_t;

    typedef struct packed {
        logic hdr;
        logic tail;
        logic [`WRRA_DATA_W-1:0] data;
    } body_view_t;

    // hdr bit tells which view applies
    typedef union packed {
        head_view_t head;
        body_view_t body;
    } flit_t;

endpackage

/* rtl/weight_counter.sv */
`timescale 1ns/1ps

module weight_counter (
    input  logic             clk,
    input  logic             counter_is_reset,
    input  wrra_pkg::weight_t weight_i,  // effective weight, never zero
    input  logic             decr_i,
    output logic             consumed_o
);

    wrra_pkg::weight_t cnt_q;
    wrra_pkg::weight_t cnt_d;

    assign consumed_o = (cnt_q == '0);

    always_comb begin
        cnt_d = cnt_q;
        if (cnt_q > weight_i) begin
            cnt_d = weight_i - 1'b1;  // weight shrank below count
        end
        if (decr_i) begin
            // a consumed counter starts a new round instead of wrapping
            cnt_d = consumed_o ? weight_i - 1'b1 : cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (counter_is_reset) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

endmodule

/* rtl/wrr_arbiter.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module wrr_arbiter (
    input  logic                clk,
    input  logic                counter_is_reset,
    input  wrra_pkg::port_vec_t req_i,
    input  wrra_pkg::weight_t   weight_i [`WRRA_P],
    input  wrra_pkg::port_vec_t tail_i,
    output wrra_pkg::port_vec_t grant_o
);

    wrra_pkg::port_idx_t ptr_q;  // highest priority input
    wrra_pkg::port_idx_t win_idx;
    wrra_pkg::port_vec_t consumed;
    logic                tail_won;

    for (genvar i = 0; i < `WRRA_P; i++) begin : g_cnt
        weight_counter u_weight_counter (
            .clk             (clk),
            .counter_is_reset(counter_is_reset),
            .weight_i        (weight_i[i]),
            .decr_i          (grant_o[i] & tail_i[i]),
            .consumed_o      (consumed[i])
        );
    end

    // search upward from the pointer, wrapping at the last port
    always_comb begin : pick
        int  idx;
        logic found;
        grant_o = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < `WRRA_P; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= `WRRA_P) begin
                idx = idx - `WRRA_P;
            end
            if (!found && req_i[idx]) begin
                grant_o[idx] = 1'b1;
                win_idx      = wrra_pkg::port_idx_t'(idx);
                found        = 1'b1;
            end
        end
    end

    assign tail_won = |(grant_o & tail_i);

    // priority stays on the winner until its weight is used up
    always_ff @(posedge clk) begin
        if (counter_is_reset) begin
            ptr_q <= '0;
        end else if (tail_won && consumed[win_idx]) begin
            if (win_idx == wrra_pkg::port_idx_t'(`WRRA_P - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

endmodule

/* rtl/input_route.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module input_route (
    input  logic                clk,
    input  logic                counter_is_reset,
    input  logic                valid_i,
    input  wrra_pkg::flit_t     flit_i,
    input  wrra_pkg::port_vec_t grant_i,  // one bit from each output
    output wrra_pkg::port_vec_t req_o,
    output wrra_pkg::weight_t   weight_o,
    output logic                tail_o,
    output logic                ready_o
);

    logic                is_hdr;
    logic                xfer;
    logic                in_pkt_q;  // between header and tail
    wrra_pkg::port_idx_t dest_q;
    wrra_pkg::weight_t   weight_q;
    wrra_pkg::weight_t   hdr_weight;

    assign is_hdr     = flit_i.head.hdr;
    assign hdr_weight = (flit_i.head.weight == '0) ? wrra_pkg::weight_t'(1) : flit_i.head.weight;
    assign tail_o     = flit_i.body.tail;  // same bit in both views
    assign weight_o   = (valid_i && is_hdr) ? hdr_weight : weight_q;

    // body flits follow the destination latched at their header
    always_comb begin
        for (int j = 0; j < `WRRA_P; j++) begin
            if (is_hdr) begin
                req_o[j] = valid_i && (flit_i.head.dest == wrra_pkg::port_idx_t'(j));
            end else begin
                req_o[j] = valid_i && in_pkt_q && (dest_q == wrra_pkg::port_idx_t'(j));
            end
        end
    end

    assign ready_o = |grant_i;
    assign xfer    = valid_i && ready_o;

    always_ff @(posedge clk) begin
        if (counter_is_reset) begin
            in_pkt_q <= 1'b0;
            weight_q <= wrra_pkg::weight_t'(1);
        end else if (xfer) begin
            in_pkt_q <= !tail_o;
            if (is_hdr) begin
                weight_q <= hdr_weight;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && is_hdr) begin
            dest_q <= flit_i.head.dest;
        end
    end

endmodule

/* rtl/output_port_ctrl.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module output_port_ctrl (
    input  logic                clk,
    input  logic                counter_is_reset,
    input  wrra_pkg::port_vec_t req_i,  // one bit per input
    input  wrra_pkg::port_vec_t tail_i,
    input  wrra_pkg::weight_t   weight_i [`WRRA_P],
    output wrra_pkg::port_vec_t grant_o
);

    logic                locked_q;
    logic                win_tail;
    wrra_pkg::port_vec_t owner_q;  // one-hot input holding the output
    wrra_pkg::port_vec_t arb_req;

    // a locked output only sees its owner, so the arbiter grants it
    // and the owner's counter still counts its packets
    always_comb begin
        if (counter_is_reset) begin
            arb_req = '0;
        end else if (locked_q) begin
            arb_req = req_i & owner_q;
        end else begin
            arb_req = req_i;
        end
    end

    wrr_arbiter u_wrr_arbiter (
        .clk             (clk),
        .counter_is_reset(counter_is_reset),
        .req_i           (arb_req),
        .weight_i        (weight_i),
        .tail_i          (tail_i),
        .grant_o         (grant_o)
    );

    assign win_tail = |(grant_o & tail_i);

    // packet lock, opened by the granted tail flit
    always_ff @(posedge clk) begin
        if (counter_is_reset) begin
            locked_q <= 1'b0;
            owner_q  <= '0;
        end else if (|grant_o) begin
            locked_q <= !win_tail;
            owner_q  <= grant_o;
        end
    end

endmodule

/* rtl/contention_gen.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module contention_gen (
    input  wrra_pkg::port_vec_t req_i [`WRRA_P],  // per input, bit per output
    input  wrra_pkg::weight_t   weight_i [`WRRA_P],
    output wrra_pkg::weight_t   contention_o [`WRRA_P]  // per output
);

    localparam logic [`WRRA_SUM_W-1:0] SAT = (1 << `WRRA_WEIGHT_W) - 1;

    // equal propagation: every requester adds its own weight
    always_comb begin : sum_per_out
        logic [`WRRA_SUM_W-1:0] sum;
        for (int j = 0; j < `WRRA_P; j++) begin
            sum = '0;
            for (int i = 0; i < `WRRA_P; i++) begin
                if (req_i[i][j]) begin
                    sum = sum + `WRRA_SUM_W'(weight_i[i]);
                end
            end
            if (sum > SAT) begin
                contention_o[j] = '1;  // saturate
            end else begin
                contention_o[j] = sum[`WRRA_WEIGHT_W-1:0];
            end
        end
    end

endmodule

/* rtl/hdr_weight_update.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module hdr_weight_update (
    input  logic                clk,
    input  logic                counter_is_reset,
    input  wrra_pkg::port_vec_t grant_i [`WRRA_P],  // per output, bit per input
    input  wrra_pkg::flit_t     flit_i [`WRRA_P],
    input  wrra_pkg::weight_t   contention_i [`WRRA_P],
    output wrra_pkg::port_vec_t out_valid_o,
    output wrra_pkg::flit_t     out_flit_o [`WRRA_P]
);

    wrra_pkg::flit_t sel_flit [`WRRA_P];
    wrra_pkg::flit_t new_flit [`WRRA_P];

    always_comb begin
        for (int j = 0; j < `WRRA_P; j++) begin
            sel_flit[j] = '0;
            for (int i = 0; i < `WRRA_P; i++) begin
                if (grant_i[j][i]) begin
                    sel_flit[j] = sel_flit[j] | flit_i[i];  // grants are one-hot
                end
            end
            new_flit[j] = sel_flit[j];
            // the local port keeps the weight it came with
            if (j != 0 && sel_flit[j].head.hdr) begin
                new_flit[j].head.weight = contention_i[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `WRRA_P; j++) begin
            if (counter_is_reset) begin
                out_valid_o[j] <= 1'b0;
            end else begin
                out_valid_o[j] <= |grant_i[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `WRRA_P; j++) begin
            out_flit_o[j] <= new_flit[j];
        end
    end

endmodule

/* rtl/wrra_switch_alloc.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module wrra_switch_alloc (
    input  logic                     clk,
    input  logic                     counter_is_reset,
    input  wrra_pkg::port_vec_t      in_valid_i,
    input  wrra_pkg::flit_t          in_flit_i [`WRRA_P],
    output wire wrra_pkg::port_vec_t in_ready_o,
    output wrra_pkg::port_vec_t      out_valid_o,
    output wrra_pkg::flit_t          out_flit_o [`WRRA_P]
);

    // in_* indexed by input, out_* indexed by output
    wire wrra_pkg::port_vec_t in_req [`WRRA_P];
    wire wrra_pkg::port_vec_t out_req [`WRRA_P];
    wire wrra_pkg::port_vec_t in_grant [`WRRA_P];
    wire wrra_pkg::port_vec_t out_grant [`WRRA_P];
    wire wrra_pkg::port_vec_t in_tail;
    wire wrra_pkg::weight_t   in_weight [`WRRA_P];
    wire wrra_pkg::weight_t   contention [`WRRA_P];

    for (genvar i = 0; i < `WRRA_P; i++) begin : g_in
        input_route u_input_route (
            .clk             (clk),
            .counter_is_reset(counter_is_reset),
            .valid_i         (in_valid_i[i]),
            .flit_i          (in_flit_i[i]),
            .grant_i         (in_grant[i]),
            .req_o           (in_req[i]),
            .weight_o        (in_weight[i]),
            .tail_o          (in_tail[i]),
            .ready_o         (in_ready_o[i])
        );
    end

    // transpose between input and output views
    for (genvar j = 0; j < `WRRA_P; j++) begin : g_xpose_out
        for (genvar i = 0; i < `WRRA_P; i++) begin : g_xpose_in
            assign out_req[j][i]  = in_req[i][j];
            assign in_grant[i][j] = out_grant[j][i];
        end
    end

    for (genvar j = 0; j < `WRRA_P; j++) begin : g_out
        output_port_ctrl u_output_port_ctrl (
            .clk             (clk),
            .counter_is_reset(counter_is_reset),
            .req_i           (out_req[j]),
            .tail_i          (in_tail),
            .weight_i        (in_weight),
            .grant_o         (out_grant[j])
        );
    end

    contention_gen u_contention_gen (
        .req_i       (in_req),
        .weight_i    (in_weight),
        .contention_o(contention)
    );

    hdr_weight_update u_hdr_weight_update (
        .clk             (clk),
        .counter_is_reset(counter_is_reset),
        .grant_i         (out_grant),
        .flit_i          (in_flit_i),
        .contention_i    (contention),
        .out_valid_o     (out_valid_o),
        .out_flit_o      (out_flit_o)
    );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic counter_is_reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        counter_is_reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        counter_is_reset = 1'b0;
    end

endmodule

/* tb/wrra_ref_model.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module wrra_ref_model (
    input  logic                clk,
    input  logic                counter_is_reset,
    input  wrra_pkg::port_vec_t valid_i,
    input  wrra_pkg::flit_t     flit_i [`WRRA_P],
    output wrra_pkg::port_vec_t ready_o,
    output wrra_pkg::port_vec_t out_valid_o,
    output wrra_pkg::flit_t     out_flit_o [`WRRA_P]
);

    logic                pkt_q [`WRRA_P];  // input inside a packet
    wrra_pkg::port_idx_t dest_q [`WRRA_P];
    int                  wq [`WRRA_P];
    logic                locked_q [`WRRA_P];
    int                  owner_q [`WRRA_P];
    int                  ptr_q [`WRRA_P];
    int                  cnt_q [`WRRA_P][`WRRA_P];  // output, input

    int                  eff [`WRRA_P];
    logic                tl [`WRRA_P];
    logic                rq [`WRRA_P][`WRRA_P];  // input, output
    int                  win [`WRRA_P];  // -1 when no grant
    wrra_pkg::flit_t     nf [`WRRA_P];

    always_comb begin : arbitrate
        int sum;
        int idx;
        int w;
        for (int i = 0; i < `WRRA_P; i++) begin
            tl[i] = flit_i[i].body.tail;  // tail sits at the same bit in both views
            if (flit_i[i].head.hdr) begin
                w = int'(flit_i[i].head.weight);
                eff[i] = valid_i[i] ? ((w == 0) ? 1 : w) : wq[i];
                for (int j = 0; j < `WRRA_P; j++)
                    rq[i][j] = valid_i[i] && (int'(flit_i[i].head.dest) == j);
            end else begin
                eff[i] = wq[i];
                for (int j = 0; j < `WRRA_P; j++)
                    rq[i][j] = valid_i[i] && pkt_q[i] && (int'(dest_q[i]) == j);
            end
        end
        ready_o = '0;
        for (int j = 0; j < `WRRA_P; j++) begin
            sum = 0;
            for (int i = 0; i < `WRRA_P; i++)
                if (rq[i][j]) sum = sum + eff[i];
            win[j] = -1;
            if (!counter_is_reset) begin
                for (int k = 0; k < `WRRA_P; k++) begin
                    idx = (ptr_q[j] + k) % `WRRA_P;
                    if (win[j] < 0 && rq[idx][j] && (!locked_q[j] || owner_q[j] == idx))
                        win[j] = idx;
                end
            end
            nf[j] = '0;
            if (win[j] >= 0) begin
                nf[j] = flit_i[win[j]];
                ready_o[win[j]] = 1'b1;
            end
            if (j != 0 && nf[j].head.hdr)
                nf[j].head.weight = wrra_pkg::weight_t'((sum > 15) ? 15 : sum);
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `WRRA_P; j++) begin
            if (counter_is_reset) begin
                locked_q[j] <= 1'b0;
                owner_q[j] <= 0;
                ptr_q[j] <= 0;
                out_valid_o[j] <= 1'b0;
                for (int i = 0; i < `WRRA_P; i++) cnt_q[j][i] <= 0;
            end else begin
                out_valid_o[j] <= (win[j] >= 0);
                out_flit_o[j] <= nf[j];
                if (win[j] >= 0) begin
                    locked_q[j] <= !tl[win[j]];
                    owner_q[j] <= win[j];
                    if (tl[win[j]] && cnt_q[j][win[j]] == 0)
                        ptr_q[j] <= (win[j] + 1) % `WRRA_P;  // weight used up
                end
                for (int i = 0; i < `WRRA_P; i++) begin
                    if (win[j] == i && tl[i])
                        cnt_q[j][i] <= (cnt_q[j][i] == 0) ? eff[i] - 1 : cnt_q[j][i] - 1;
                    else if (cnt_q[j][i] > eff[i])
                        cnt_q[j][i] <= eff[i] - 1;
                end
            end
        end
        for (int i = 0; i < `WRRA_P; i++) begin
            if (counter_is_reset) begin
                pkt_q[i] <= 1'b0;
                wq[i] <= 1;
            end else if (valid_i[i] && ready_o[i]) begin
                pkt_q[i] <= !tl[i];
                if (flit_i[i].head.hdr) begin
                    wq[i] <= eff[i];
                    dest_q[i] <= flit_i[i].head.dest;
                end
            end
        end
    end

endmodule

/* tb/tb_wrra_switch_alloc.sv */
`timescale 1ns/1ps
`include "wrra_consts.svh"

module tb_wrra_switch_alloc;

    localparam int T_LONE = 40;
    localparam int T_CONT = 200;
    localparam int T_WRR = 400;
    localparam int T_PKT = 400;
    localparam int T_MIX = 2000;
    localparam int LIMIT = 2 * (16 + T_LONE + T_CONT + T_WRR + T_PKT + T_MIX);

    logic                clk;
    logic                counter_is_reset;
    wrra_pkg::port_vec_t in_valid;
    wrra_pkg::flit_t     in_flit [`WRRA_P];
    wrra_pkg::port_vec_t in_ready;
    wrra_pkg::port_vec_t out_valid;
    wrra_pkg::flit_t     out_flit [`WRRA_P];
    wrra_pkg::port_vec_t m_ready;
    wrra_pkg::port_vec_t m_valid;
    wrra_pkg::flit_t     m_flit [`WRRA_P];

    integer seed = 32'h03eb_d1b2;
    int     errors = 0;
    int     cycles = 0;
    logic   accepted [`WRRA_P];
    int     remaining [`WRRA_P];  // body flits still to send
    int     seq [`WRRA_P];
    int     dest_sel [`WRRA_P];  // -1 picks at random
    int     wsel [`WRRA_P];
    int     dut_acc [`WRRA_P];
    int     mdl_acc [`WRRA_P];
    logic   open_pkt [`WRRA_P];  // output is inside a packet
    int     open_id [`WRRA_P];
    int     open_seq [`WRRA_P];
    wrra_pkg::port_vec_t active;
    int     maxlen;
    int     start_pct;
    int     gap_pct;
    int     err_mark;

    tb_clk_gen i_clk_gen (.clk(clk), .counter_is_reset(counter_is_reset));

    wrra_ref_model i_model (
        .clk(clk), .counter_is_reset(counter_is_reset), .valid_i(in_valid),
        .flit_i(in_flit), .ready_o(m_ready), .out_valid_o(m_valid), .out_flit_o(m_flit)
    );

    wrra_switch_alloc i_dut (
        .clk(clk), .counter_is_reset(counter_is_reset), .in_valid_i(in_valid),
        .in_flit_i(in_flit), .in_ready_o(in_ready), .out_valid_o(out_valid),
        .out_flit_o(out_flit)
    );

    function automatic int rand_below(int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // next flit for every input whose previous flit has gone
    task automatic drive_inputs();
        int len;
        int d;
        for (int i = 0; i < `WRRA_P; i++) begin
            if (!(in_valid[i] && !accepted[i])) begin
                in_valid[i] = 1'b0;
                if (remaining[i] > 0) begin
                    if (rand_below(100) >= gap_pct) begin
                        seq[i]++;
                        in_flit[i] = {1'b0, remaining[i] == 1, 19'b0, 8'(seq[i]), 3'(i)};
                        in_valid[i] = 1'b1;
                        remaining[i]--;
                    end
                end else if (active[i] && rand_below(100) < start_pct) begin
                    len = 1 + rand_below(maxlen);
                    d = (dest_sel[i] < 0) ? rand_below(`WRRA_P) : dest_sel[i];
                    in_flit[i] = {1'b1, len == 1, 3'(d),
                                  4'((wsel[i] < 0) ? rand_below(16) : wsel[i]), 20'b0, 3'(i)};
                    in_valid[i] = 1'b1;
                    remaining[i] = len - 1;
                    seq[i] = 0;
                end
            end
        end
    endtask

    // compares with the model and tracks packet order on each output
    task automatic compare_all();
        for (int i = 0; i < `WRRA_P; i++) begin
            check_value($sformatf("in_ready_o[%0d]", i), m_ready[i], in_ready[i]);
            accepted[i] = in_valid[i] && in_ready[i];
            if (accepted[i]) dut_acc[i]++;
            if (in_valid[i] && m_ready[i]) mdl_acc[i]++;
        end
        for (int j = 0; j < `WRRA_P; j++) begin
            check_value($sformatf("out_valid_o[%0d]", j), m_valid[j], out_valid[j]);
            if (m_valid[j])
                check_value($sformatf("out_flit_o[%0d]", j), m_flit[j], out_flit[j]);
            if (out_valid[j] === 1'b1) begin
                if (out_flit[j].head.hdr) begin
                    if (open_pkt[j]) begin
                        $display("header interleaved into an open packet on output %0d", j);
                        errors++;
                    end
                    open_pkt[j] = !out_flit[j].head.tail;
                    open_id[j] = out_flit[j].head.payload[2:0];
                    open_seq[j] = 0;
                end else begin
                    open_seq[j]++;
                    if (!open_pkt[j] || open_id[j] != out_flit[j].body.data[2:0] ||
                        open_seq[j] != out_flit[j].body.data[10:3]) begin
                        $display("body flit out of order on output %0d", j);
                        errors++;
                    end
                    if (out_flit[j].body.tail) open_pkt[j] = 1'b0;
                end
            end
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            drive_inputs();
            #10;
            compare_all();
        end
    endtask

    task automatic setup(input wrra_pkg::port_vec_t act, input int len, input int pct,
                         input int gap);
        active = act;
        maxlen = len;
        start_pct = pct;
        gap_pct = gap;
        err_mark = errors;
        for (int i = 0; i < `WRRA_P; i++) begin
            dest_sel[i] = -1;
            wsel[i] = -1;
            dut_acc[i] = 0;
            mdl_acc[i] = 0;
        end
    endtask

    task automatic report(input string name);
        $display("test %s: %s (%0d errors)", name, (errors == err_mark) ? "ok" : "failed",
                 errors - err_mark);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        in_valid = '0;
        for (int i = 0; i < `WRRA_P; i++) begin
            in_flit[i] = '0;
            accepted[i] = 1'b0;
            remaining[i] = 0;
            seq[i] = 0;
            open_pkt[i] = 1'b0;
        end
        setup('0, 1, 0, 0);
        // the lone packet already waits while reset is high
        in_valid[2] = 1'b1;
        in_flit[2] = {1'b1, 1'b1, 3'd0, 4'd5, 23'h2a_5a52};  // lone packet to local port
        while (counter_is_reset !== 1'b0) begin
            @(negedge clk);
            #10;
            if (counter_is_reset) begin
                check_value("in_ready_o", 0, in_ready);
                check_value("out_valid_o", 0, out_valid);
            end
        end

        compare_all();
        while (!accepted[2]) run_cycles(1);
        run_cycles(1);
        check_value("out_valid_o[0]", 1, out_valid[0]);
        check_value("out_flit_o[0]", {1'b1, 1'b1, 3'd0, 4'd5, 23'h2a_5a52}, out_flit[0]);
        run_cycles(T_LONE);
        report("lone_packet");

        setup(5'b11010, 2, 60, 0);
        for (int i = 0; i < `WRRA_P; i++) dest_sel[i] = 3;
        run_cycles(T_CONT);
        report("contention");

        setup(5'b00011, 1, 100, 0);
        dest_sel[0] = 2;
        dest_sel[1] = 2;
        wsel[0] = 3;
        wsel[1] = 0;  // counts as weight 1
        run_cycles(20);  // older packets leave first
        for (int i = 0; i < `WRRA_P; i++) begin
            dut_acc[i] = 0;
            mdl_acc[i] = 0;
        end
        run_cycles(T_WRR - 40);
        for (int i = 0; i < 2; i++)
            check_value($sformatf("accept count %0d", i), mdl_acc[i], dut_acc[i]);
        // weights 3 and 1 share output 2 three to one
        if (dut_acc[0] > 3 * dut_acc[1] + 3 || dut_acc[0] + 3 < 3 * dut_acc[1]) begin
            $display("output 2 not shared 3 to 1: input 0 won %0d and input 1 won %0d packets",
                     dut_acc[0], dut_acc[1]);
            errors++;
        end
        active = '0;
        run_cycles(20);
        report("weighted_rr");

        setup(5'b01110, 5, 70, 20);
        for (int i = 0; i < `WRRA_P; i++) dest_sel[i] = 4;
        run_cycles(T_PKT - 40);
        active = '0;
        run_cycles(40);
        report("no_interleave");

        setup(5'b11111, 4, 50, 25);
        run_cycles(T_MIX);
        for (int i = 0; i < `WRRA_P; i++)
            check_value($sformatf("accept count %0d", i), mdl_acc[i], dut_acc[i]);
        report("random_mix");

        $display("checks done after %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+rtl
rtl/wrra_pkg.sv
rtl/weight_counter.sv
rtl/wrr_arbiter.sv
rtl/input_route.sv
rtl/output_port_ctrl.sv
rtl/contention_gen.sv
rtl/hdr_weight_update.sv
rtl/wrra_switch_alloc.sv
tb/tb_clk_gen.sv
tb/wrra_ref_model.sv
tb/tb_wrra_switch_alloc.sv

/* Bender.yml */
package:
  name: wrra_switch_alloc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wrra_pkg.sv
      - rtl/weight_counter.sv
      - rtl/wrr_arbiter.sv
      - rtl/input_route.sv
      - rtl/output_port_ctrl.sv
      - rtl/contention_gen.sv
      - rtl/hdr_weight_update.sv
      - rtl/wrra_switch_alloc.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_clk_gen.sv
      - tb/wrra_ref_model.sv
      - tb/tb_wrra_switch_alloc.sv
